//--- rtl/sa_pkg.sv
`default_nettype none

package sa_pkg;

  //////////////////////////////
  // element widths
  //////////////////////////////

  localparam int ACT_W = 8;
  localparam int WGT_W = 8;

  // growth room above the raw 8x8 product
  localparam int HEADROOM = 8;
  localparam int ACC_W = 16 + HEADROOM;

  // array side limits
  localparam int MAX_DIM = 16;
  localparam int IDX_W = 4;

  //////////////////////////////
  // element types
  //////////////////////////////

  typedef logic signed [ACT_W-1:0] act_t;
  typedef logic signed [WGT_W-1:0] wgt_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // requantized result
  typedef logic signed [7:0] out_t;

  // weight row load strobe
  typedef struct packed {
    logic             en;
    logic [IDX_W-1:0] row;
  } wload_t;

endpackage

`default_nettype wire

//--- rtl/mac_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
  input  wire                clk,
  input  wire                w_we,
  input  wire  sa_pkg::wgt_t w_in,
  input  wire  sa_pkg::act_t a_in,
  input  wire  sa_pkg::acc_t psum_in,
  output sa_pkg::act_t       a_out,
  output sa_pkg::acc_t       psum_out
);

  localparam int PROD_W = sa_pkg::ACT_W + sa_pkg::WGT_W;

  sa_pkg::wgt_t              w_reg;
  logic signed [PROD_W-1:0]  prod;

  //////////////////////////////
  // stationary weight
  //////////////////////////////

  // held until the row is reloaded
  always_ff @(posedge clk) begin
    if (w_we) begin
      w_reg <= w_in;
    end
  end

  //////////////////////////////
  // multiply-accumulate
  //////////////////////////////

  // full signed 8x8 product
  assign prod = PROD_W'(a_in) * PROD_W'(w_reg);

  // partial sum moves one row down per cycle
  always_ff @(posedge clk) begin
    psum_out <= psum_in + sa_pkg::acc_t'(prod);
  end

  // activation moves one column right per cycle
  always_ff @(posedge clk) begin
    a_out <= a_in;
  end

endmodule

`default_nettype wire

//--- rtl/row_skew.sv
`timescale 1ns/1ps
`default_nettype none

module row_skew #(
  parameter int N = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        a_valid,
  input  wire  sa_pkg::act_t [N-1:0] a_vec,
  output sa_pkg::act_t [N-1:0]       skew_vec,
  output logic                       skew_valid
);

  sa_pkg::act_t [N-1:0] a_gated;

  // bubbles enter as zeros so they add nothing downstream
  assign a_gated = a_valid ? a_vec : '0;

  //////////////////////////////
  // per-row delay lines
  //////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    // row i sees i+1 registers
    sa_pkg::act_t [i:0] line;

    always_ff @(posedge clk) begin
      line[0] <= a_gated[i];
      for (int k = 1; k <= i; k++) begin
        line[k] <= line[k-1];
      end
    end

    assign skew_vec[i] = line[i];
  end

  //////////////////////////////
  // valid strobe
  //////////////////////////////

  // travels with row 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      skew_valid <= 1'b0;
    end else begin
      skew_valid <= a_valid;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array #(
  parameter int N = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire  sa_pkg::wload_t       wl,
  input  wire  sa_pkg::wgt_t [N-1:0] w_vec,
  input  wire  sa_pkg::act_t [N-1:0] skew_vec,
  input  wire                        skew_valid,
  output sa_pkg::acc_t [N-1:0]       col_sum,
  output logic                       col_valid
);

  logic [N-1:0]  row_we;
  logic [N-1:0]  vld_dly;
  // horizontal activation links and vertical partial sum links
  sa_pkg::act_t  a_link [N][N+1];
  sa_pkg::acc_t  p_link [N+1][N];

  // one row write enable per load strobe
  always_comb begin
    for (int i = 0; i < N; i++) begin
      row_we[i] = wl.en && (int'(wl.row) == i);
    end
  end

  //////////////////////////////
  // cell grid
  //////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    assign a_link[i][0] = skew_vec[i];
    for (genvar j = 0; j < N; j++) begin : g_col
      mac_pe mac_pe_inst (
        .clk      (clk),
        .w_we     (row_we[i]),
        .w_in     (w_vec[j]),
        .a_in     (a_link[i][j]),
        .psum_in  (p_link[i][j]),
        .a_out    (a_link[i][j+1]),
        .psum_out (p_link[i+1][j])
      );
    end
  end

  // zeros into the top, finished sums out the bottom
  for (genvar j = 0; j < N; j++) begin : g_edge
    assign p_link[0][j] = '0;
    assign col_sum[j]   = p_link[N][j];
  end

  // valid lines up with column 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_dly <= '0;
    end else begin
      vld_dly <= {vld_dly[N-2:0], skew_valid};
    end
  end
  assign col_valid = vld_dly[N-1];

  // a load aimed past the last row would write no cell
  a_wl_row: assert property (@(posedge clk) disable iff (!rst_n) wl.en |-> int'(wl.row) < N);
  a_dim: assert property (@(posedge clk) N >= 2 && N <= sa_pkg::MAX_DIM);

endmodule

`default_nettype wire

//--- rtl/sum_deskew.sv
`timescale 1ns/1ps
`default_nettype none

module sum_deskew #(
  parameter int N = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire  sa_pkg::acc_t [N-1:0] col_sum,
  input  wire                        col_valid,
  output sa_pkg::acc_t [N-1:0]       row_sum,
  output logic                       row_valid
);

  logic [N-1:0] vld_dly;

  //////////////////////////////
  // per-column delay chains
  //////////////////////////////

  // column j arrives j cycles after column 0, so it waits N-j cycles
  for (genvar j = 0; j < N; j++) begin : g_col
    localparam int DEPTH = N - j;

    sa_pkg::acc_t [DEPTH-1:0] chain;

    always_ff @(posedge clk) begin
      chain[0] <= col_sum[j];
      for (int k = 1; k < DEPTH; k++) begin
        chain[k] <= chain[k-1];
      end
    end

    // last stage is the output register
    assign row_sum[j] = chain[DEPTH-1];
  end

  //////////////////////////////
  // valid chain
  //////////////////////////////

  // matches column 0's depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_dly <= '0;
    end else begin
      vld_dly <= {vld_dly[N-2:0], col_valid};
    end
  end
  assign row_valid = vld_dly[N-1];

  // upstream valids are all reset, so no X may reach requantize
  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(row_valid)
  );

endmodule

`default_nettype wire

//--- rtl/requant_stage.sv
`timescale 1ns/1ps
`default_nettype none

module requant_stage #(
  parameter int N = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire  [4:0]                 cfg_shift,
  input  wire  sa_pkg::acc_t [N-1:0] row_sum,
  input  wire                        row_valid,
  output sa_pkg::out_t [N-1:0]       y_vec,
  output logic                       y_valid
);

  // one spare bit so the rounding bias cannot overflow
  localparam int SUM_W = sa_pkg::ACC_W + 1;

  sa_pkg::out_t [N-1:0] y_next;

  // round half up, arithmetic shift, clamp to signed 8 bits
  function automatic sa_pkg::out_t requant(sa_pkg::acc_t s, logic [4:0] sh);
    logic signed [SUM_W-1:0] wide;
    logic signed [SUM_W-1:0] bias;
    logic signed [SUM_W-1:0] shifted;
    wide = SUM_W'(s);
    bias = '0;
    if (sh != 5'd0) begin
      bias = SUM_W'(1) << (sh - 5'd1);
    end
    shifted = (wide + bias) >>> sh;
    if (shifted > 127) begin
      return 8'sd127;
    end else if (shifted < -128) begin
      return -8'sd128;
    end
    return shifted[7:0];
  endfunction

  always_comb begin
    for (int j = 0; j < N; j++) begin
      y_next[j] = requant(row_sum[j], cfg_shift);
    end
  end

  always_ff @(posedge clk) begin
    y_vec <= y_next;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_valid <= 1'b0;
    end else begin
      y_valid <= row_valid;
    end
  end

  a_shift_range: assert property (
    @(posedge clk) disable iff (!rst_n) row_valid |-> cfg_shift <= 5'd23
  );

endmodule

`default_nettype wire

//--- rtl/sa_top.sv
`timescale 1ns/1ps
`default_nettype none

module sa_top #(
  parameter int N = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire  [4:0]                 cfg_shift,
  input  wire  sa_pkg::wload_t       wl,
  input  wire  sa_pkg::wgt_t [N-1:0] w_vec,
  input  wire                        a_valid,
  input  wire  sa_pkg::act_t [N-1:0] a_vec,
  output logic                       y_valid,
  output sa_pkg::out_t [N-1:0]       y_vec
);

  //////////////////////////////
  // stage links
  //////////////////////////////

  sa_pkg::act_t [N-1:0] skew_vec;
  logic                 skew_valid;
  sa_pkg::acc_t [N-1:0] col_sum;
  logic                 col_valid;
  sa_pkg::acc_t [N-1:0] row_sum;
  logic                 row_valid;

  // skew 1, array N, deskew N, requantize 1
  row_skew #(.N(N)) row_skew_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_valid    (a_valid),
    .a_vec      (a_vec),
    .skew_vec   (skew_vec),
    .skew_valid (skew_valid)
  );

  pe_array #(.N(N)) pe_array_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wl         (wl),
    .w_vec      (w_vec),
    .skew_vec   (skew_vec),
    .skew_valid (skew_valid),
    .col_sum    (col_sum),
    .col_valid  (col_valid)
  );

  sum_deskew #(.N(N)) sum_deskew_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_sum   (col_sum),
    .col_valid (col_valid),
    .row_sum   (row_sum),
    .row_valid (row_valid)
  );

  requant_stage #(.N(N)) requant_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_shift (cfg_shift),
    .row_sum   (row_sum),
    .row_valid (row_valid),
    .y_vec     (y_vec),
    .y_valid   (y_valid)
  );

endmodule

`default_nettype wire

//--- bench/sa_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sa_tb;

  localparam int N = 4;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int SEED = 32'hbe5f;
  localparam int MAX_GAP = 3;
  localparam int LATENCY = 2 * N + 2;
  // every record is padded to the widest line, an A line
  localparam int REC_W = 2 * N;

  logic                 clk;
  logic                 rst_n;
  logic [4:0]           cfg_shift;
  sa_pkg::wload_t       wl;
  sa_pkg::wgt_t [N-1:0] w_vec;
  logic                 a_valid;
  sa_pkg::act_t [N-1:0] a_vec;
  logic                 y_valid;
  sa_pkg::out_t [N-1:0] y_vec;

  byte    kinds [$];
  int     fields [$];
  int     exp_q [$];
  int     launch_q [$];
  int     line_count = 0;
  int     cyc = 0;
  int     value_errors = 0;
  int     other_errors = 0;
  bit     loaded = 1'b0;
  integer seed;

  sa_top #(.N(N)) sa_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_shift (cfg_shift),
    .wl        (wl),
    .w_vec     (w_vec),
    .a_valid   (a_valid),
    .a_vec     (a_vec),
    .y_valid   (y_valid),
    .y_vec     (y_vec)
  );

  //////////////////////////////
  // clock and cycle count
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input int got, input int expected);
    if (got !== expected) begin
      value_errors++;
      $display("ERROR %s got %08h expected %08h at cycle %0d", name, got, expected, cyc);
    end
  endtask

  task automatic close_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // W, S and A lines become records, a blank line becomes a gap record
  task automatic load_vectors();
    int    fd;
    int    n;
    byte   tag;
    bit    ok;
    string line;
    int    f [REC_W];
    fd = $fopen("bench/sa_vectors.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open bench/sa_vectors.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      line_count++;
      tag = line.getc(0);
      if (tag == "#") begin
        continue;
      end
      for (int k = 0; k < REC_W; k++) begin
        f[k] = 0;
      end
      // field layout below is written for N = 4
      if (tag == "W") begin
        n = $sscanf(line, "W %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
        ok = (n == N + 1);
      end else if (tag == "S") begin
        n = $sscanf(line, "S %d", f[0]);
        ok = (n == 1);
      end else if (tag == "A") begin
        n = $sscanf(line, "A %d %d %d %d %d %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        ok = (n == 2 * N);
      end else if (tag == 0 || tag == "\n" || tag == "\r" || tag == " ") begin
        tag = "G";
        ok = 1'b1;
      end else begin
        ok = 1'b0;
      end
      if (!ok) begin
        other_errors++;
        $display("malformed line %0d in bench/sa_vectors.txt", line_count);
      end else begin
        kinds.push_back(tag);
        for (int k = 0; k < REC_W; k++) begin
          fields.push_back(f[k]);
        end
      end
    end
    $fclose(fd);
  endtask

  // nothing may be in flight when weights or shift change
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic load_weights(input int base);
    wl.en = 1'b1;
    wl.row = 4'(fields[base]);
    for (int j = 0; j < N; j++) begin
      w_vec[j] = sa_pkg::wgt_t'(fields[base + 1 + j]);
    end
    @(negedge clk);
    wl = '0;
  endtask

  task automatic drive_vector(input int base);
    for (int j = 0; j < N; j++) begin
      a_vec[j] = sa_pkg::act_t'(fields[base + j]);
      exp_q.push_back(fields[base + N + j]);
    end
    launch_q.push_back(cyc);
    a_valid = 1'b1;
    @(negedge clk);
    a_valid = 1'b0;
    a_vec = '0;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    int gap;
    int base;
    rst_n = 1'b0;
    cfg_shift = '0;
    wl = '0;
    w_vec = '0;
    a_valid = 1'b0;
    a_vec = '0;
    seed = SEED;
    load_vectors();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int r = 0; r < kinds.size(); r++) begin
      base = r * REC_W;
      case (kinds[r])
        "W": begin
          wait_drain();
          load_weights(base);
        end
        "S": begin
          wait_drain();
          cfg_shift = 5'(fields[base]);
        end
        "A": drive_vector(base);
        default: begin
          gap = {$random(seed)} % (MAX_GAP + 1);
          repeat (gap) @(negedge clk);
        end
      endcase
    end
    wait_drain();
    // long enough for a stray pulse to show up
    repeat (LATENCY + 2) @(negedge clk);
    close_run();
  end

  //////////////////////////////
  // result monitor
  //////////////////////////////

  always @(negedge clk) begin : monitor
    int expected;
    if (y_valid) begin
      if (exp_q.size() < N) begin
        other_errors++;
        $display("y_valid pulsed at cycle %0d with no result pending", cyc);
      end else begin
        check_value("y_valid latency", cyc - launch_q.pop_front(), LATENCY);
        for (int j = 0; j < N; j++) begin
          expected = exp_q.pop_front();
          check_value($sformatf("y_vec[%0d]", j), int'(y_vec[j]), expected);
        end
      end
    end
  end

  // budget per line covers the widest gap plus a full drain
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = RST_CYCLES + line_count * (3 + LATENCY) + 50;
    repeat (limit) @(posedge clk);
    other_errors++;
    $display("run timed out after %0d cycles before all vectors were done", limit);
    close_run();
  end

endmodule

`default_nettype wire

//--- bench/sa_vectors.txt
# W row w0 w1 w2 w3 | S shift | A a0 a1 a2 a3 y0 y1 y2 y3, all decimal
# a blank line closes a group of back-to-back A lines
W 0 1 2 3 4
W 1 -1 0 2 1
W 2 3 -2 1 0
W 3 0 1 -1 2
S 0
A 1 1 1 1 3 1 5 7

A 2 -1 0 3 3 7 1 13
A -5 4 2 -3 -3 -17 -2 -22
A 10 0 -7 1 -11 35 22 42
A 1 1 1 1 3 1 5 7

A 100 100 100 100 127 100 127 127
A -100 -100 -100 -100 -128 -100 -128 -128
A 127 -128 127 -128 127 -128 127 124

S 4
A 8 0 0 0 1 1 2 2
A -8 0 0 0 0 -1 -1 -2
A 50 20 -10 7 0 8 11 15
A 127 127 127 127 24 8 40 56

S 8
A 127 127 127 127 1 0 2 3
A 64 0 0 0 0 1 1 1
A -64 0 0 0 0 0 -1 -1
A 0 0 -128 0 -1 1 0 0

W 2 0 0 0 5
S 0
A 2 -1 0 3 3 7 1 13
A -5 4 2 -3 -9 -13 -4 -12

A 10 0 -7 1 10 21 29 7
A 1 1 1 1 0 3 4 12

//--- build.f
rtl/sa_pkg.sv
rtl/mac_pe.sv
rtl/row_skew.sv
rtl/pe_array.sv
rtl/sum_deskew.sv
rtl/requant_stage.sv
rtl/sa_top.sv
bench/sa_tb.sv

//--- Makefile
# Verilator build and run for the systolic array testbench

TOP := sa_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f build.f -Mdir obj_dir

# the verdict comes from the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
